// File: Makefile
# simulation tool, its flags, top module and file list
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps --Mdir obj_dir
TOP      = nf_pwm_tb
FILELIST = nf_pwm.f
BIN      = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the testbench printed its pass line
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// File: design/nf_ahb_pwm.sv
// AHB-Lite slave front end of the pwm peripheral, address phase capture and request issue
`timescale 1ns/1ps
`include "nf_pwm_settings.svh"

module nf_ahb_pwm (
    // clock and reset
    input   logic   [0  : 0]        hclk,       // bus clock
    input   logic   [0  : 0]        rst_n,      // async reset, active low
    // AHB-Lite slave side
    input   logic   [0  : 0]        hsel_s,     // slave select
    input   logic   [1  : 0]        htrans_s,   // transfer type
    input   logic   [31 : 0]        haddr_s,    // address, address phase
    input   logic   [0  : 0]        hwrite_s,   // direction, address phase
    input   logic   [31 : 0]        hwdata_s,   // write data, data phase
    output  logic   [31 : 0]        hrdata_s,   // read data, data phase
    output  logic   [0  : 0]        hready_s,   // data phase done
    // register block side
    output  nf_pwm_pkg::pwm_req_t   req,        // one request per transfer
    input   logic   [31 : 0]        rdata       // read-back from register block
);

    localparam logic [1 : 0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1 : 0] HTRANS_SEQ    = 2'b11;

    logic                   request;            // transfer in this address phase
    logic   [`NF_PWM_ADDR_BITS-1 : 0] word_addr;    // aligned low address
    nf_pwm_pkg::pwm_reg_e   reg_idx;            // decoded register, address phase

    logic                   request_q;          // data phase flag
    logic                   write_q;            // data phase direction
    nf_pwm_pkg::pwm_reg_e   reg_idx_q;          // data phase register

    assign request   = hsel_s && ((htrans_s == HTRANS_NONSEQ) || (htrans_s == HTRANS_SEQ));
    assign word_addr = {haddr_s[`NF_PWM_ADDR_BITS-1 : 2], 2'b00};   // byte lanes dropped

    // offset to register index
    always_comb begin
        case (word_addr)
            `NF_PWM_CTRL_OFS   : reg_idx = nf_pwm_pkg::PWM_REG_CTRL;
            `NF_PWM_PERIOD_OFS : reg_idx = nf_pwm_pkg::PWM_REG_PERIOD;
            `NF_PWM_DUTY_OFS   : reg_idx = nf_pwm_pkg::PWM_REG_DUTY;
            `NF_PWM_COUNT_OFS  : reg_idx = nf_pwm_pkg::PWM_REG_COUNT;
            default            : reg_idx = nf_pwm_pkg::PWM_REG_CTRL;    // not reachable at 4 bits
        endcase
    end

    // address phase registers, sampled every cycle since the slave never stalls
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            request_q <= 1'b0;
            write_q   <= 1'b0;
            reg_idx_q <= nf_pwm_pkg::PWM_REG_CTRL;
        end else begin
            request_q <= request;
            write_q   <= request && hwrite_s;   // only a real write counts
            reg_idx_q <= reg_idx;
        end
    end

    // data phase
    assign req.valid   = request_q;
    assign req.write   = write_q;
    assign req.reg_idx = reg_idx_q;
    assign req.wdata   = hwdata_s;      // master drives it now
    assign hready_s    = request_q;     // single wait-free data cycle
    assign hrdata_s    = rdata;         // combinational read-back

endmodule : nf_ahb_pwm

// File: design/nf_pwm_gen.sv
// pwm generator with period counter, boundary-loaded shadow registers and registered output
`timescale 1ns/1ps
`include "nf_pwm_settings.svh"

module nf_pwm_gen (
    // clock and reset
    input   logic   [0  : 0]                hclk,   // clock
    input   logic   [0  : 0]                rst_n,  // async reset, active low
    // configuration
    input   nf_pwm_pkg::pwm_cfg_t           cfg,    // from register block
    // outputs
    output  logic   [`NF_PWM_WIDTH-1 : 0]   count,  // period counter
    output  logic   [0  : 0]                pwm     // pwm output
);

    localparam int W = `NF_PWM_WIDTH;

    logic               enable_q;       // enable one cycle ago
    logic   [W-1 : 0]   shadow_period;  // period in use
    logic   [W-1 : 0]   shadow_duty;    // duty in use
    logic               wrap;           // last cycle of the period

    logic   [W-1 : 0]   count_nxt;
    logic   [W-1 : 0]   period_nxt;
    logic   [W-1 : 0]   duty_nxt;
    logic               pwm_nxt;

    // one extra bit so count+1 never overflows
    assign wrap = ({1'b0, count} + 1'b1) >= {1'b0, shadow_period};

    always_comb begin
        count_nxt  = count + 1'b1;      // plain step
        period_nxt = shadow_period;
        duty_nxt   = shadow_duty;
        if (!cfg.enable) begin
            count_nxt = '0;             // held while stopped
        end else if (!enable_q || wrap) begin
            // start or period boundary picks up new values
            count_nxt  = '0;
            period_nxt = cfg.period;
            duty_nxt   = cfg.duty;
        end
        // compare on next values so pwm lines up with count
        pwm_nxt = cfg.enable && (count_nxt < duty_nxt);
    end

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q      <= 1'b0;
            count         <= '0;
            shadow_period <= '0;
            shadow_duty   <= '0;
            pwm           <= 1'b0;
        end else begin
            enable_q      <= cfg.enable;
            count         <= count_nxt;
            shadow_period <= period_nxt;
            shadow_duty   <= duty_nxt;
            pwm           <= pwm_nxt;   // glitch free output
        end
    end

endmodule : nf_pwm_gen

// File: design/nf_pwm_pkg.sv
// register index enum and the request, configuration structs of the pwm peripheral
`include "nf_pwm_settings.svh"

package nf_pwm_pkg;

    // one entry per 32-bit register word
    typedef enum logic [1 : 0] {
        PWM_REG_CTRL    = 2'd0,     // enable
        PWM_REG_PERIOD  = 2'd1,     // period
        PWM_REG_DUTY    = 2'd2,     // duty
        PWM_REG_COUNT   = 2'd3      // counter read-back
    } pwm_reg_e;

    // bus front end to register block, valid in the data phase only
    typedef struct packed {
        logic               valid;      // one cycle per transfer
        logic               write;      // 1 write, 0 read
        pwm_reg_e           reg_idx;    // decoded register
        logic   [31 : 0]    wdata;      // hwdata of the data phase
    } pwm_req_t;

    // register block to generator
    typedef struct packed {
        logic                           enable;     // generator run
        logic   [`NF_PWM_WIDTH-1 : 0]   period;     // requested period
        logic   [`NF_PWM_WIDTH-1 : 0]   duty;       // requested duty
    } pwm_cfg_t;

endpackage : nf_pwm_pkg

// File: design/nf_pwm_regs.sv
// pwm register block with write decode, read-back mux and generator configuration
`timescale 1ns/1ps
`include "nf_pwm_settings.svh"

module nf_pwm_regs (
    // clock and reset
    input   logic   [0  : 0]                hclk,   // bus clock
    input   logic   [0  : 0]                rst_n,  // async reset, active low
    // bus front end side
    input   nf_pwm_pkg::pwm_req_t           req,    // data phase request
    output  logic   [31 : 0]                rdata,  // read-back word
    // generator side
    output  nf_pwm_pkg::pwm_cfg_t           cfg,    // enable, period, duty
    input   logic   [`NF_PWM_WIDTH-1 : 0]   count   // live counter
);

    localparam int PAD = 32 - `NF_PWM_WIDTH;    // zero bits above a value

    nf_pwm_pkg::pwm_cfg_t   cfg_q;      // register storage
    logic                   wr_en;      // write strobe

    assign wr_en = req.valid && req.write;

    // write decode, count is read only
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (wr_en) begin
            case (req.reg_idx)
                nf_pwm_pkg::PWM_REG_CTRL   : cfg_q.enable <= req.wdata[0];
                nf_pwm_pkg::PWM_REG_PERIOD : cfg_q.period <= req.wdata[`NF_PWM_WIDTH-1 : 0];
                nf_pwm_pkg::PWM_REG_DUTY   : cfg_q.duty   <= req.wdata[`NF_PWM_WIDTH-1 : 0];
                default                    : ;     // write to count dropped
            endcase
        end
    end

    // read-back, zero extended
    always_comb begin
        case (req.reg_idx)
            nf_pwm_pkg::PWM_REG_CTRL   : rdata = {31'b0, cfg_q.enable};
            nf_pwm_pkg::PWM_REG_PERIOD : rdata = {{PAD{1'b0}}, cfg_q.period};
            nf_pwm_pkg::PWM_REG_DUTY   : rdata = {{PAD{1'b0}}, cfg_q.duty};
            nf_pwm_pkg::PWM_REG_COUNT  : rdata = {{PAD{1'b0}}, count};  // straight from generator
            default                    : rdata = '0;
        endcase
    end

    assign cfg = cfg_q;     // shadowing happens in the generator

endmodule : nf_pwm_regs

// File: design/nf_pwm_settings.svh
// counter width, register byte offsets and decoded address bits of the pwm peripheral
`ifndef NF_PWM_SETTINGS_SVH
`define NF_PWM_SETTINGS_SVH

// width of counter, period and duty (8 or 16)
`define NF_PWM_WIDTH        8

// low address bits seen by the register decoder
`define NF_PWM_ADDR_BITS    4

// byte offsets of the four 32-bit registers
`define NF_PWM_CTRL_OFS     4'h0        // bit 0 enable
`define NF_PWM_PERIOD_OFS   4'h4        // period in hclk cycles
`define NF_PWM_DUTY_OFS     4'h8        // high cycles per period
`define NF_PWM_COUNT_OFS    4'hc        // live counter, read only

`endif

// File: design/nf_pwm_top.sv
// pwm peripheral top level wiring the AHB front end, register block and generator
`timescale 1ns/1ps
`include "nf_pwm_settings.svh"

module nf_pwm_top (
    // clock and reset
    input   logic   [0  : 0]    hclk,       // bus clock
    input   logic   [0  : 0]    rst_n,      // async reset, active low
    // AHB-Lite slave side
    input   logic   [0  : 0]    hsel_s,     // slave select
    input   logic   [1  : 0]    htrans_s,   // transfer type
    input   logic   [31 : 0]    haddr_s,    // address
    input   logic   [0  : 0]    hwrite_s,   // direction
    input   logic   [31 : 0]    hwdata_s,   // write data
    output  logic   [31 : 0]    hrdata_s,   // read data
    output  logic   [0  : 0]    hready_s,   // data phase done
    // pwm side
    output  logic   [0  : 0]    pwm         // pwm output
);

    nf_pwm_pkg::pwm_req_t           req;    // front end to registers
    logic   [31 : 0]                rdata;  // registers to front end
    nf_pwm_pkg::pwm_cfg_t           cfg;    // registers to generator
    logic   [`NF_PWM_WIDTH-1 : 0]   count;  // generator to registers

    nf_ahb_pwm nf_ahb_pwm_inst (
        .hclk       ( hclk      ),
        .rst_n      ( rst_n     ),
        .hsel_s     ( hsel_s    ),
        .htrans_s   ( htrans_s  ),
        .haddr_s    ( haddr_s   ),
        .hwrite_s   ( hwrite_s  ),
        .hwdata_s   ( hwdata_s  ),
        .hrdata_s   ( hrdata_s  ),
        .hready_s   ( hready_s  ),
        .req        ( req       ),
        .rdata      ( rdata     )
    );

    nf_pwm_regs nf_pwm_regs_inst (
        .hclk       ( hclk      ),
        .rst_n      ( rst_n     ),
        .req        ( req       ),
        .rdata      ( rdata     ),
        .cfg        ( cfg       ),
        .count      ( count     )
    );

    nf_pwm_gen nf_pwm_gen_inst (
        .hclk       ( hclk      ),
        .rst_n      ( rst_n     ),
        .cfg        ( cfg       ),
        .count      ( count     ),
        .pwm        ( pwm       )
    );

endmodule : nf_pwm_top

// File: nf_pwm.f
+incdir+design
design/nf_pwm_pkg.sv
design/nf_ahb_pwm.sv
design/nf_pwm_regs.sv
design/nf_pwm_gen.sv
design/nf_pwm_top.sv
tests/nf_pwm_properties.sv
tests/nf_pwm_tb.sv

// File: tests/nf_pwm_properties.sv
// concurrent checks on the bus handshake, pwm gating and counter range, bound to the pwm top level
`timescale 1ns/1ps
`include "nf_pwm_settings.svh"

module nf_pwm_properties (
    input   logic   [0  : 0]                hclk,           // bus clock
    input   logic   [0  : 0]                rst_n,          // async reset, active low
    input   logic   [0  : 0]                hsel_s,         // slave select
    input   logic   [1  : 0]                htrans_s,       // transfer type
    input   logic   [0  : 0]                hready_s,       // data phase done
    input   logic   [0  : 0]                pwm,            // pwm output
    input   nf_pwm_pkg::pwm_cfg_t           cfg,            // register block outputs
    input   logic   [`NF_PWM_WIDTH-1 : 0]   count,          // period counter
    input   logic   [`NF_PWM_WIDTH-1 : 0]   shadow_period   // period in use
);

    int unsigned fail_count = 0;    // number of failed assertions

    // NONSEQ and SEQ both have bit 1 set
    property idle_gives_no_ready;
        @(posedge hclk) disable iff (!rst_n)
            !(hsel_s && htrans_s[1]) |=> !hready_s;
    endproperty

    // output is registered, so it drops one cycle later
    property stopped_gives_low;
        @(posedge hclk) disable iff (!rst_n)
            !cfg.enable |=> !pwm;
    endproperty

    property count_in_period;
        @(posedge hclk) disable iff (!rst_n)
            (shadow_period != '0) |-> (count < shadow_period);
    endproperty

    idle_ready_chk: assert property (idle_gives_no_ready)
        else begin
            fail_count++;
            $error("hready_s high after a cycle without a transfer");
        end

    stopped_low_chk: assert property (stopped_gives_low)
        else begin
            fail_count++;
            $error("pwm high while the generator is disabled");
        end

    count_range_chk: assert property (count_in_period)
        else begin
            fail_count++;
            $error("count reached the shadow period");
        end

endmodule : nf_pwm_properties

bind nf_pwm_top nf_pwm_properties nf_pwm_properties_inst (
    .hclk           ( hclk                          ),
    .rst_n          ( rst_n                         ),
    .hsel_s         ( hsel_s                        ),
    .htrans_s       ( htrans_s                      ),
    .hready_s       ( hready_s                      ),
    .pwm            ( pwm                           ),
    .cfg            ( cfg                           ),
    .count          ( count                         ),
    .shadow_period  ( nf_pwm_gen_inst.shadow_period )
);

// File: tests/nf_pwm_stimulus.txt
# op ofs data expected, all hex; W write, R read and compare, B read and expect below
# M wait for data completed periods then high count, Q high count over data cycles
R 0 00000000 00000000
R 4 00000000 00000000
R 8 00000000 00000000
R c 00000000 00000000
Q 0 00000014 00000000
W 4 000000a5 00000000
R 4 00000000 000000a5
W 8 0000003c 00000000
R 8 00000000 0000003c
W 0 fffffffe 00000000
R 0 00000000 00000000
W c 000000ff 00000000
R c 00000000 00000000
W 4 00000014 00000000
W 8 00000005 00000000
W 0 00000001 00000000
R 0 00000000 00000001
M 0 00000003 00000005
W 8 00000000 00000000
M 0 00000003 00000000
W 8 0000001e 00000000
M 0 00000003 00000014
W 8 00000006 00000000
M 0 00000003 00000006
W 8 0000000f 00000000
M 0 00000001 00000006
M 0 00000001 0000000f
B c 00000000 00000014
W 0 00000000 00000000
R c 00000000 00000000
Q 0 00000014 00000000

// File: tests/nf_pwm_tb.sv
// testbench for the pwm peripheral with AHB master tasks, stimulus file reader, checks and watchdog
`timescale 1ns/1ps
`include "nf_pwm_settings.svh"

module nf_pwm_tb;

    localparam int          W             = `NF_PWM_WIDTH;
    localparam string       STIM_FILE     = "tests/nf_pwm_stimulus.txt";
    localparam logic [31:0] BASE_ADDR     = 32'h4000_0000;    // upper bits ignored by the slave
    localparam logic [1:0]  HTRANS_IDLE   = 2'b00;
    localparam logic [1:0]  HTRANS_NONSEQ = 2'b10;
    localparam int          READY_LIMIT   = 8;                // cycles allowed for hready_s

    // one line of the stimulus file
    typedef struct packed {
        logic   [7  : 0]    op;         // W R B M Q
        logic   [3  : 0]    ofs;        // register byte offset
        logic   [31 : 0]    data;       // write data, periods or cycles
        logic   [31 : 0]    exp_val;    // expected value or bound
    } step_t;

    logic   [0  : 0]    hclk;
    logic   [0  : 0]    rst_n;
    logic   [0  : 0]    hsel_s;
    logic   [1  : 0]    htrans_s;
    logic   [31 : 0]    haddr_s;
    logic   [0  : 0]    hwrite_s;
    logic   [31 : 0]    hwdata_s;
    logic   [31 : 0]    hrdata_s;
    logic   [0  : 0]    hready_s;
    logic   [0  : 0]    pwm;

    step_t              steps [$];          // whole stimulus file
    logic   [W-1 : 0]   cur_period;         // last period written
    longint unsigned    watchdog_ns;        // run limit in ns once the steps are loaded

    // period monitor state
    logic   [31 : 0]    run_len;            // cycles of the period in progress
    logic   [31 : 0]    run_high;           // high cycles so far
    logic   [31 : 0]    done_len;           // last completed period
    logic   [31 : 0]    done_high;
    int unsigned        periods_done;       // completed periods since reset

    nf_pwm_top nf_pwm_top_inst (
        .hclk       ( hclk      ),
        .rst_n      ( rst_n     ),
        .hsel_s     ( hsel_s    ),
        .htrans_s   ( htrans_s  ),
        .haddr_s    ( haddr_s   ),
        .hwrite_s   ( hwrite_s  ),
        .hwdata_s   ( hwdata_s  ),
        .hrdata_s   ( hrdata_s  ),
        .hready_s   ( hready_s  ),
        .pwm        ( pwm       )
    );

    always #50 hclk = ~hclk;    // 100 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp_val,
                               input logic [3:0] ofs);
        if (got !== exp_val) begin
            abort_run($sformatf("** Error: hrdata_s = 0x%08h, expected 0x%08h at offset 0x%0h",
                                got, exp_val, ofs));
        end
    endtask

    task automatic check_below(input logic [31:0] got, input logic [31:0] bound);
        if (!(got < bound)) begin
            abort_run($sformatf("** Error: hrdata_s = 0x%08h, expected below 0x%08h",
                                got, bound));
        end
    endtask

    task automatic check_pwm_high(input logic [W-1:0] got, input logic [W-1:0] exp_val);
        if (got !== exp_val) begin
            abort_run($sformatf("** Error: pwm high cycles = 0x%0h, expected 0x%0h",
                                got, exp_val));
        end
    endtask

    task automatic check_period_len(input logic [W-1:0] got, input logic [W-1:0] exp_val);
        if (got !== exp_val) begin
            abort_run($sformatf("** Error: count period length = 0x%0h, expected 0x%0h",
                                got, exp_val));
        end
    endtask

    // data phase ends on the first negedge with hready_s high
    task automatic wait_ready();
        int unsigned cycles;
        cycles = 0;
        @(negedge hclk);
        while (hready_s !== 1'b1 && cycles < READY_LIMIT) begin
            cycles++;
            @(negedge hclk);
        end
        if (hready_s !== 1'b1) begin
            abort_run("bus transfer never ended, hready_s stayed low");
        end
    endtask

    task automatic write_reg(input logic [3:0] ofs, input logic [31:0] data);
        @(posedge hclk);                    // address phase
        hsel_s   <= 1'b1;
        htrans_s <= HTRANS_NONSEQ;
        haddr_s  <= BASE_ADDR | {28'h0, ofs};
        hwrite_s <= 1'b1;
        @(posedge hclk);                    // data phase
        hsel_s   <= 1'b0;
        htrans_s <= HTRANS_IDLE;
        hwrite_s <= 1'b0;
        hwdata_s <= data;
        wait_ready();
    endtask

    task automatic read_reg(input logic [3:0] ofs, output logic [31:0] data);
        @(posedge hclk);
        hsel_s   <= 1'b1;
        htrans_s <= HTRANS_NONSEQ;
        haddr_s  <= BASE_ADDR | {28'h0, ofs};
        hwrite_s <= 1'b0;
        @(posedge hclk);
        hsel_s   <= 1'b0;
        htrans_s <= HTRANS_IDLE;
        wait_ready();
        data = hrdata_s;                    // stable mid data phase
    endtask

    // period boundaries seen where count is back at zero
    always @(negedge hclk) begin
        if (rst_n) begin
            if (nf_pwm_top_inst.count == '0 && run_len != 32'd0) begin
                done_len  = run_len;
                done_high = run_high;
                run_len   = 32'd1;
                run_high  = {31'd0, pwm};
                periods_done++;             // last, so waiters see a full record
            end else begin
                run_len  = run_len + 32'd1;
                run_high = run_high + {31'd0, pwm};
            end
        end
    end

    // waits for periods to complete and checks the last one
    task automatic measure_period(input int unsigned skip, input logic [W-1:0] exp_high);
        int unsigned target;
        @(posedge hclk);                    // off the monitor's edge
        target = periods_done + skip;
        wait (periods_done >= target);
        check_period_len(done_len[W-1:0], cur_period);
        check_pwm_high(done_high[W-1:0], exp_high);
    endtask

    task automatic count_high_cycles(input int unsigned cycles, input logic [W-1:0] exp_high);
        logic [W-1:0] high;
        high = '0;
        @(posedge hclk);
        repeat (cycles) begin
            @(negedge hclk);
            high = high + {{(W-1){1'b0}}, pwm};
        end
        check_pwm_high(high, exp_high);
    endtask

    task automatic load_steps();
        int             fd;
        int             n;
        string          line;
        logic   [7:0]   op;
        logic   [31:0]  ofs;
        logic   [31:0]  data;
        logic   [31:0]  exp_val;
        step_t          s;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin     // skip comments and blanks
                    n = $sscanf(line, "%c %h %h %h", op, ofs, data, exp_val);
                    if (n != 4) begin
                        abort_run($sformatf("bad stimulus line: %s", line));
                    end else begin
                        s.op      = op;
                        s.ofs     = ofs[3:0];
                        s.data    = data;
                        s.exp_val = exp_val;
                        steps.push_back(s);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] got;
        case (s.op)
            "W": begin
                write_reg(s.ofs, s.data);
                if (s.ofs == `NF_PWM_PERIOD_OFS) begin
                    cur_period = s.data[W-1:0];     // length for later measures
                end
            end
            "R": begin
                read_reg(s.ofs, got);
                check_rdata(got, s.exp_val, s.ofs);
            end
            "B": begin
                read_reg(s.ofs, got);
                check_below(got, s.exp_val);
            end
            "M": measure_period(s.data, s.exp_val[W-1:0]);
            "Q": count_high_cycles(s.data, s.exp_val[W-1:0]);
            default: abort_run($sformatf("unknown operation %c in the stimulus file", s.op));
        endcase
    endtask

    initial begin : watchdog
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        abort_run($sformatf("timeout, the run did not finish within %0d ns", watchdog_ns));
    end

    // a failed assertion ends the run at once
    initial begin : assertion_watch
        wait (nf_pwm_top_inst.nf_pwm_properties_inst.fail_count != 0);
        abort_run("an assertion failed during the run");
    end

    initial begin : main
        logic [W-1:0] max_period;
        hclk         = 1'b0;
        rst_n        <= 1'b0;
        hsel_s       <= 1'b0;
        htrans_s     <= HTRANS_IDLE;
        haddr_s      <= '0;
        hwrite_s     <= 1'b0;
        hwdata_s     <= '0;
        cur_period   = '0;
        watchdog_ns  = 0;
        run_len      = '0;
        run_high     = '0;
        done_len     = '0;
        done_high    = '0;
        periods_done = 0;
        load_steps();
        max_period = 1;
        foreach (steps[i]) begin
            if (steps[i].op == "W" && steps[i].ofs == `NF_PWM_PERIOD_OFS &&
                steps[i].data[W-1:0] > max_period) begin
                max_period = steps[i].data[W-1:0];
            end
        end
        // steps times largest period times two clock periods
        watchdog_ns = longint'(steps.size()) * longint'(max_period) * 64'd200;
        repeat (3) @(posedge hclk);
        rst_n <= 1'b1;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        @(negedge hclk);
        if (nf_pwm_top_inst.nf_pwm_properties_inst.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("an assertion failed during the run");
        end
    end

endmodule : nf_pwm_tb
